//--- all.f
+incdir+logic
logic/alu_ctrl_pkg.sv
logic/alu_cp_pkg.sv
logic/cp_bus_if.sv
logic/alu_prefix_adder.sv
logic/alu_cp_shifter.sv
logic/alu_cp_monitor.sv
logic/alu_top.sv
testbench/alu_checker.sv
testbench/alu_scoreboard.sv
testbench/alu_tb.sv

//--- Bender.yml
package:
  name: alu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/alu_ctrl_pkg.sv
      - logic/alu_cp_pkg.sv
      - logic/cp_bus_if.sv
      - logic/alu_prefix_adder.sv
      - logic/alu_cp_shifter.sv
      - logic/alu_cp_monitor.sv
      - logic/alu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/alu_checker.sv
      - testbench/alu_scoreboard.sv
      - testbench/alu_tb.sv

//--- testbench/alu_tb.sv
// ------------------------------------------------
// top-level testbench of the ALU
// random and edge-value ops, serial shifts, timeout and trap
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_tb;

    localparam int clk_period = 100;
    localparam int n_random   = 200;                           // single-cycle ops
    localparam int n_edge     = 5;                             // edge values
    localparam int n_shift    = 12;                            // random shifts
    localparam int exc_wait   = (1 << `ALU_CP_TIMEOUT_BITS) + 4;
    // reset, random, edge pairs, shifts, timeout, abort
    localparam int run_cycles = 2 + n_random + 2 * n_edge * n_edge
                              + (n_shift + 2) * (`ALU_XLEN + 5) + exc_wait + 8 + `ALU_XLEN + 8;
    localparam int watchdog_cycles = run_cycles + 200;

    logic                    clk_i, rstn_i;
    alu_ctrl_pkg::alu_op_e   alu_op_i;
    alu_ctrl_pkg::shift_op_e shift_op_i;
    logic                    opa_pc_i, opb_imm_i, unsigned_i, trap_i;
    logic [`ALU_CP_NUM-1:0]  cp_trig_i;
    logic [`ALU_XLEN-1:0]    rs1_i, rs2_i, pc_i, imm_i, res_o, add_o;
    logic [1:0]              cmp_o;
    logic                    exc_o, cp_done_o;
    int                      sb_checks, sb_errors, tb_errors;
    integer                  seed;
    logic [`ALU_XLEN-1:0]    edge_val [n_edge] = '{0, 32'h8000_0000, 32'h7fff_ffff,
                                                   32'hffff_ffff, 1};

    alu_top dut_i (.*);

    alu_scoreboard u_scoreboard (
        .*,
        .cmp_i     (cmp_o),
        .res_i     (res_o),
        .add_i     (add_o),
        .exc_i     (exc_o),
        .cp_done_i (cp_done_o),
        .checks_o  (sb_checks),
        .errors_o  (sb_errors)
    );

    always #(clk_period / 2) clk_i = ~clk_i;

    task automatic drive_random_op();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == alu_ctrl_pkg::CP)
            r[2:0] = alu_ctrl_pkg::ADD;  // single-cycle ops only
        @(posedge clk_i);
        alu_op_i   <= alu_ctrl_pkg::alu_op_e'(r[2:0]);
        opa_pc_i   <= r[3];
        opb_imm_i  <= r[4];
        unsigned_i <= r[5];
        rs1_i      <= $random(seed);
        rs2_i      <= $random(seed);
        pc_i       <= $random(seed);
        imm_i      <= $random(seed);
    endtask

    task automatic drive_compare(input logic [`ALU_XLEN-1:0] a, b, input logic uns);
        @(posedge clk_i);
        alu_op_i   <= alu_ctrl_pkg::SLT;
        opa_pc_i   <= 1'b0;
        opb_imm_i  <= 1'b0;
        unsigned_i <= uns;
        rs1_i      <= a;
        rs2_i      <= b;
    endtask

    task automatic run_shift(input alu_ctrl_pkg::shift_op_e op,
                             input logic [`ALU_XLEN-1:0] val,
                             input logic [`ALU_SHAMT_W-1:0] amt);
        int n;
        @(posedge clk_i);
        alu_op_i   <= alu_ctrl_pkg::CP;
        shift_op_i <= op;
        opb_imm_i  <= 1'b0;
        rs1_i      <= val;
        rs2_i      <= amt;      // shamt from low bits of b
        cp_trig_i  <= 2'b01;    // slot SHIFT
        @(posedge clk_i);
        cp_trig_i  <= '0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (cp_done_o !== 1'b1 && n < `ALU_XLEN + 2);
        if (cp_done_o !== 1'b1) begin
            tb_errors++;
            $display("ERROR time %0t: shift by %0d reported no done", $time, amt);
        end
        repeat (2) @(posedge clk_i);  // result held
    endtask

    task automatic run_timeout();
        int n;
        @(posedge clk_i);
        alu_op_i  <= alu_ctrl_pkg::ADD;
        cp_trig_i <= 2'b10;     // slot RESERVED, never answers
        @(posedge clk_i);
        cp_trig_i <= '0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (exc_o !== 1'b1 && n < exc_wait);
        if (exc_o !== 1'b1) begin
            tb_errors++;
            $display("ERROR time %0t: no timeout exception after %0d cycles", $time, n);
        end
        @(posedge clk_i);
        trap_i <= 1'b1;
        @(posedge clk_i);
        trap_i <= 1'b0;
        repeat (3) @(posedge clk_i);
    endtask

    task automatic run_abort();
        run_shift_start: begin
            @(posedge clk_i);
            alu_op_i   <= alu_ctrl_pkg::CP;
            shift_op_i <= alu_ctrl_pkg::SLL;
            rs1_i      <= $random(seed);
            rs2_i      <= `ALU_XLEN - 1;  // longest shift
            cp_trig_i  <= 2'b01;
            @(posedge clk_i);
            cp_trig_i  <= '0;
        end
        repeat (5) @(posedge clk_i);
        trap_i <= 1'b1;
        @(posedge clk_i);
        trap_i <= 1'b0;
        repeat (`ALU_XLEN + 4) @(posedge clk_i);  // no done may follow
    endtask

    initial begin
        logic [31:0] r;
        int          total;
        seed       = 42123;
        tb_errors  = 0;
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        alu_op_i   = alu_ctrl_pkg::ADD;
        shift_op_i = alu_ctrl_pkg::SLL;
        opa_pc_i   = 1'b0;
        opb_imm_i  = 1'b0;
        unsigned_i = 1'b0;
        trap_i     = 1'b0;
        cp_trig_i  = '0;
        rs1_i      = '0;
        rs2_i      = '0;
        pc_i       = '0;
        imm_i      = '0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        repeat (n_random) drive_random_op();
        for (int u = 0; u < 2; u++)
            for (int i = 0; i < n_edge; i++)
                for (int j = 0; j < n_edge; j++)
                    drive_compare(edge_val[i], edge_val[j], u[0]);

        run_shift(alu_ctrl_pkg::SRA, 32'h8765_4321, '0);  // shamt 0
        for (int i = 0; i < n_shift; i++) begin
            r = $random(seed);
            run_shift(alu_ctrl_pkg::shift_op_e'(r[1:0] % 3), $random(seed), r[6:2]);
        end
        run_timeout();
        run_abort();

        @(negedge clk_i);
        total = sb_errors + tb_errors + dut_i.u_checker.assert_fails;
        $display("checks %0d, errors %0d", sb_checks, total);
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: run did not finish within %0d cycles", watchdog_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- testbench/alu_scoreboard.sv
// ------------------------------------------------
// scoreboard, predicts ALU outputs from the inputs
// compares on every negedge, counts checks and errors
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_scoreboard (
    input  logic                    clk_i, rstn_i,
    input  alu_ctrl_pkg::alu_op_e   alu_op_i,
    input  alu_ctrl_pkg::shift_op_e shift_op_i,
    input  logic                    opa_pc_i, opb_imm_i, unsigned_i, trap_i,
    input  logic [`ALU_CP_NUM-1:0]  cp_trig_i,
    input  logic [`ALU_XLEN-1:0]    rs1_i, rs2_i, pc_i, imm_i,
    input  logic [1:0]              cmp_i,
    input  logic [`ALU_XLEN-1:0]    res_i, add_i,
    input  logic                    exc_i, cp_done_i,
    output int                      checks_o,
    output int                      errors_o
);

    localparam int exc_limit = (1 << `ALU_CP_TIMEOUT_BITS) + 4;  // cycles until timeout

    logic                 busy, held;            // shift in flight, result held
    int                   wait_cnt;              // negedges until done
    logic [`ALU_XLEN-1:0] shift_exp;
    logic                 rsv_active, rsv_seen;  // reserved slot pending, exc seen
    int                   rsv_cnt;

    // expected {cmp, add, res} for the single-cycle ops
    function automatic logic [2*`ALU_XLEN+1:0] alu_ref(
        input alu_ctrl_pkg::alu_op_e op,
        input logic                  uns, a_pc, b_imm,
        input logic [`ALU_XLEN-1:0]  rs1, rs2, pc, imm
    );
        logic [`ALU_XLEN-1:0] a, b, sum, res;
        logic [1:0]           cmp;
        a   = a_pc ? pc : rs1;
        b   = b_imm ? imm : rs2;
        sum = (op == alu_ctrl_pkg::SUB || op == alu_ctrl_pkg::SLT) ? a - b : a + b;
        case (op)
            alu_ctrl_pkg::ADD, alu_ctrl_pkg::SUB: res = sum;
            alu_ctrl_pkg::SLT:  res = uns ? (a < b) : ($signed(a) < $signed(b));
            alu_ctrl_pkg::MOVB: res = b;
            alu_ctrl_pkg::XOR:  res = rs1 ^ b;  // logic ops take rs1
            alu_ctrl_pkg::OR:   res = rs1 | b;
            alu_ctrl_pkg::AND:  res = rs1 & b;
            default:            res = '0;       // CP, see shift model
        endcase
        cmp[alu_ctrl_pkg::cmp_eq_idx] = (rs1 == rs2);
        cmp[alu_ctrl_pkg::cmp_lt_idx] = uns ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
        return {cmp, sum, res};
    endfunction

    function automatic logic [`ALU_XLEN-1:0] shift_ref(
        input alu_ctrl_pkg::shift_op_e op,
        input logic [`ALU_XLEN-1:0]    val,
        input logic [`ALU_SHAMT_W-1:0] amt
    );
        case (op)
            alu_ctrl_pkg::SLL: return val << amt;
            alu_ctrl_pkg::SRA: return $signed(val) >>> amt;  // sign fill
            default:           return val >> amt;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`ALU_XLEN-1:0] exp, got);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("MISMATCH time %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        errors_o++;
        $display("ERROR time %0t: %s", $time, msg);
    endtask

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

    always @(negedge clk_i) begin
        logic [2*`ALU_XLEN+1:0] exp;
        logic [`ALU_XLEN-1:0]   opb;
        logic                   done_exp, accept;
        if (!rstn_i) begin
            busy       = 1'b0;
            held       = 1'b0;
            rsv_active = 1'b0;
            wait_cnt   = 0;
        end else begin
            exp      = alu_ref(alu_op_i, unsigned_i, opa_pc_i, opb_imm_i,
                               rs1_i, rs2_i, pc_i, imm_i);
            opb      = opb_imm_i ? imm_i : rs2_i;
            done_exp = busy && (wait_cnt == 1);
            check_value("cmp_o", exp[2*`ALU_XLEN+1 -: 2], cmp_i);
            check_value("add_o", exp[2*`ALU_XLEN-1 -: `ALU_XLEN], add_i);
            check_value("cp_done_o", done_exp, cp_done_i);
            if (alu_op_i != alu_ctrl_pkg::CP)
                check_value("res_o", exp[`ALU_XLEN-1:0], res_i);
            else if (done_exp || !busy)
                check_value("res_o", (done_exp || held) ? shift_exp : '0, res_i);  // zero if none

            // ------------------------------------------------
            // timeout of the reserved slot
            // ------------------------------------------------
            if (exc_i && !rsv_active)
                report_failure("timeout exception without a pending reserved-slot operation");
            if (rsv_active && !rsv_seen) begin
                rsv_seen = exc_i;
                rsv_cnt++;
                if (!exc_i && rsv_cnt > exc_limit) begin
                    report_failure("reserved-slot operation raised no timeout exception");
                    rsv_active = 1'b0;
                end
            end

            // model state for the next edge
            accept = cp_trig_i[alu_cp_pkg::SHIFT] && !trap_i && !busy;  // busy ignores start
            if (busy) begin
                wait_cnt--;
                busy = !done_exp;
                held = done_exp;
            end
            if (trap_i) begin
                busy       = 1'b0;  // aborted, result cleared
                held       = 1'b0;
                rsv_active = 1'b0;
            end else if (accept) begin
                busy      = 1'b1;
                held      = 1'b0;
                wait_cnt  = opb[`ALU_SHAMT_W-1:0] + 1;  // shamt+1 cycles
                shift_exp = shift_ref(shift_op_i, rs1_i, opb[`ALU_SHAMT_W-1:0]);
            end
            if (cp_trig_i[alu_cp_pkg::RESERVED] && !trap_i) begin
                rsv_active = 1'b1;
                rsv_seen   = 1'b0;
                rsv_cnt    = 0;
            end
        end
    end

endmodule

//--- testbench/alu_checker.sv
// ------------------------------------------------
// handshake assertions, bound into alu_top
// ------------------------------------------------
`timescale 1ns/1ns

module alu_checker (
    input logic clk_i,
    input logic rstn_i,
    input logic exc_i,   // timeout exception
    input logic done_i   // co-processor done pulse
);

    int assert_fails = 0;  // read by the testbench

    done_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i) done_i |=> !done_i)
        else begin
            $error("cp_done_o high for two cycles");
            assert_fails++;
        end

    exc_not_on_done: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                      $rose(exc_i) |-> !done_i)
        else begin
            $error("exc_o rose while cp_done_o was high");
            assert_fails++;
        end

    quiet_in_reset: assert property (@(posedge clk_i) !rstn_i |-> (!exc_i && !done_i))
        else begin
            $error("exc_o or cp_done_o high during reset");
            assert_fails++;
        end

endmodule

bind alu_top alu_checker u_checker (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .exc_i  (exc_o),
    .done_i (cp_done_o)
);

//--- logic/alu_top.sv
// ------------------------------------------------
// integer ALU with branch comparator and co-processor slots
// single-cycle ops are combinational, shifts run in slot 0
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  alu_ctrl_pkg::alu_op_e     alu_op_i,    // result select
    input  alu_ctrl_pkg::shift_op_e   shift_op_i,  // shifter function
    input  logic                      opa_pc_i,    // a = pc instead of rs1
    input  logic                      opb_imm_i,   // b = imm instead of rs2
    input  logic                      unsigned_i,  // unsigned compare/slt
    input  logic [`ALU_CP_NUM-1:0]    cp_trig_i,   // co-processor start
    input  logic                      trap_i,      // abort co-processors
    input  logic [`ALU_XLEN-1:0]      rs1_i,
    input  logic [`ALU_XLEN-1:0]      rs2_i,
    input  logic [`ALU_XLEN-1:0]      pc_i,
    input  logic [`ALU_XLEN-1:0]      imm_i,
    output logic [1:0]                cmp_o,       // eq / lt
    output logic [`ALU_XLEN-1:0]      res_o,
    output logic [`ALU_XLEN-1:0]      add_o,       // address result
    output logic                      exc_o,       // co-processor timeout
    output logic                      cp_done_o
);

    logic [`ALU_XLEN:0]                     cmp_rs1;    // extended for compare
    logic [`ALU_XLEN:0]                     cmp_rs2;
    logic [`ALU_XLEN-1:0]                   opa;
    logic [`ALU_XLEN-1:0]                   opb;
    logic [`ALU_XLEN:0]                     addsub_res;
    logic                                   sub;
    logic [`ALU_CP_NUM-1:0][`ALU_XLEN-1:0]  cp_result;  // zero unless held
    logic [`ALU_CP_NUM-1:0]                 cp_valid;
    logic [`ALU_XLEN-1:0]                   cp_res;

    cp_bus_if shift_bus ();

    // ------------------------------------------------
    // branch comparator
    // ------------------------------------------------
    assign cmp_rs1 = {rs1_i[`ALU_XLEN-1] & ~unsigned_i, rs1_i};
    assign cmp_rs2 = {rs2_i[`ALU_XLEN-1] & ~unsigned_i, rs2_i};

    assign cmp_o[alu_ctrl_pkg::cmp_eq_idx] = (rs1_i == rs2_i);
    assign cmp_o[alu_ctrl_pkg::cmp_lt_idx] = signed'(cmp_rs1) < signed'(cmp_rs2);

    // ------------------------------------------------
    // operands and adder
    // ------------------------------------------------
    assign opa = opa_pc_i  ? pc_i  : rs1_i;
    assign opb = opb_imm_i ? imm_i : rs2_i;
    assign sub = (alu_op_i == alu_ctrl_pkg::SUB) || (alu_op_i == alu_ctrl_pkg::SLT);

    alu_prefix_adder #(
        .width      (`ALU_XLEN)
    ) u_adder (
        .a_i        (opa),
        .b_i        (opb),
        .sub_i      (sub),
        .unsigned_i (unsigned_i),
        .sum_o      (addsub_res)
    );

    assign add_o = addsub_res[`ALU_XLEN-1:0];

    // ------------------------------------------------
    // result select
    // ------------------------------------------------
    always_comb begin
        unique case (alu_op_i)
            alu_ctrl_pkg::ADD,
            alu_ctrl_pkg::SUB:  res_o = addsub_res[`ALU_XLEN-1:0];
            alu_ctrl_pkg::CP:   res_o = cp_res;
            alu_ctrl_pkg::SLT:  res_o = {{(`ALU_XLEN-1){1'b0}}, addsub_res[`ALU_XLEN]};  // sign bit
            alu_ctrl_pkg::MOVB: res_o = opb;
            alu_ctrl_pkg::XOR:  res_o = rs1_i ^ opb;
            alu_ctrl_pkg::OR:   res_o = rs1_i | opb;
            alu_ctrl_pkg::AND:  res_o = rs1_i & opb;
        endcase
    end

    // ------------------------------------------------
    // co-processor slots
    // ------------------------------------------------
    assign shift_bus.start    = cp_trig_i[alu_cp_pkg::SHIFT];
    assign shift_bus.opa      = rs1_i;
    assign shift_bus.shamt    = opb[`ALU_SHAMT_W-1:0];  // low bits of b
    assign shift_bus.shift_op = shift_op_i;

    alu_cp_shifter u_shifter (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .abort_i (trap_i),
        .bus     (shift_bus.unit)
    );

    assign cp_result[alu_cp_pkg::SHIFT]    = shift_bus.res;
    assign cp_valid[alu_cp_pkg::SHIFT]     = shift_bus.valid;
    assign cp_result[alu_cp_pkg::RESERVED] = '0;    // empty slot
    assign cp_valid[alu_cp_pkg::RESERVED]  = 1'b0;  // never answers

    always_comb begin
        cp_res = '0;
        for (int i = 0; i < `ALU_CP_NUM; i++) begin
            cp_res = cp_res | cp_result[i];  // idle slots give zero
        end
    end

    assign cp_done_o = |cp_valid;

    alu_cp_monitor u_monitor (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .trig_i  (cp_trig_i),  // reserved bit only seen here
        .done_i  (cp_done_o),
        .abort_i (trap_i),
        .exc_o   (exc_o)
    );

endmodule

//--- logic/alu_cp_monitor.sv
// ------------------------------------------------
// co-processor watchdog
// raises exc_o when a started operation never reports done
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_cp_monitor (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic [`ALU_CP_NUM-1:0] trig_i,   // co-processor triggers
    input  logic                   done_i,   // any co-processor valid
    input  logic                   abort_i,  // trap
    output logic                   exc_o     // timeout exception
);

    alu_cp_pkg::cp_mon_t mon;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mon <= '0;
        end else begin
            // timeout without finish, dropped by trap
            mon.exc <= mon.run & mon.cnt[`ALU_CP_TIMEOUT_BITS] & ~mon.fin & ~abort_i;
            mon.fin <= done_i;
            if (!mon.run) begin
                mon.cnt <= '0;
                if (|trig_i) begin
                    mon.run <= 1'b1;  // operation started
                end
            end else begin
                if (!mon.cnt[`ALU_CP_TIMEOUT_BITS]) begin
                    mon.cnt <= mon.cnt + 1'b1;  // holds at msb
                end
                if (mon.fin || abort_i) begin
                    mon.run <= 1'b0;  // finished or aborted
                end
            end
        end
    end

    assign exc_o = mon.exc;

endmodule

//--- logic/alu_cp_shifter.sv
// ------------------------------------------------
// bit-serial shift co-processor for sll, srl and sra
// one position per cycle, result after shamt+1 cycles
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_cp_shifter (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   abort_i,   // trap, drop the operation
    cp_bus_if.unit bus
);

    alu_cp_pkg::shift_state_e state;
    logic [`ALU_SHAMT_W-1:0]  cnt;     // positions left to shift
    logic [`ALU_XLEN-1:0]     sreg;    // shift register
    alu_ctrl_pkg::shift_op_e  op;      // latched function
    logic                     accept;  // start taken this cycle
    logic                     done;    // last position reached

    assign accept = bus.start & ~abort_i & (state != alu_cp_pkg::RUN);  // busy ignores start
    assign done   = (state == alu_cp_pkg::RUN) && (cnt == '0);

    // ------------------------------------------------
    // control FSM
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state <= alu_cp_pkg::IDLE;
            cnt   <= '0;
        end else if (abort_i) begin
            state <= alu_cp_pkg::IDLE;  // trap
            cnt   <= '0;
        end else begin
            case (state)
                alu_cp_pkg::IDLE, alu_cp_pkg::DONE: begin
                    if (accept) begin
                        state <= alu_cp_pkg::RUN;
                        cnt   <= bus.shamt;
                    end
                end
                alu_cp_pkg::RUN: begin
                    if (cnt == '0) begin
                        state <= alu_cp_pkg::DONE;  // hold result
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= alu_cp_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------------------------
    // data path
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            sreg <= bus.opa;
            op   <= bus.shift_op;
        end else if ((state == alu_cp_pkg::RUN) && (cnt != '0)) begin
            case (op)
                alu_ctrl_pkg::SLL: sreg <= {sreg[`ALU_XLEN-2:0], 1'b0};
                alu_ctrl_pkg::SRL: sreg <= {1'b0, sreg[`ALU_XLEN-1:1]};
                alu_ctrl_pkg::SRA: sreg <= {sreg[`ALU_XLEN-1], sreg[`ALU_XLEN-1:1]};  // keep sign
                default:           sreg <= sreg;
            endcase
        end
    end

    assign bus.valid = done;  // one cycle, RUN leaves next edge
    assign bus.res   = (done || (state == alu_cp_pkg::DONE)) ? sreg : '0;  // zero otherwise

endmodule

//--- logic/alu_prefix_adder.sv
// ------------------------------------------------
// parallel-prefix adder/subtracter
// operands extended by one bit, sum msb is the less-than flag
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_prefix_adder #(
    parameter int width = `ALU_XLEN
) (
    input  logic [width-1:0] a_i,
    input  logic [width-1:0] b_i,
    input  logic             sub_i,       // a - b
    input  logic             unsigned_i,  // zero-extend instead of sign-extend
    output logic [width:0]   sum_o
);

    localparam int N   = width + 1;   // extended operand width
    localparam int LVL = $clog2(N);   // prefix levels

    logic [N-1:0]          a_ext;
    logic [N-1:0]          b_ext;
    logic [N-1:0]          hsum;      // bitwise half sum
    logic [LVL:0][N-1:0]   gen;       // group generate per level
    logic [LVL:0][N-1:0]   prp;       // group propagate per level

    // ------------------------------------------------
    // operand preparation
    // ------------------------------------------------
    assign a_ext = {a_i[width-1] & ~unsigned_i, a_i};
    assign b_ext = {b_i[width-1] & ~unsigned_i, b_i} ^ {N{sub_i}};  // invert for sub

    assign hsum = a_ext ^ b_ext;

    // position 0 is the carry-in, position i+1 is bit i
    assign gen[0] = {a_ext[N-2:0] & b_ext[N-2:0], sub_i};
    assign prp[0] = {hsum[N-2:0], 1'b0};

    // ------------------------------------------------
    // prefix tree, distance doubles per level
    // ------------------------------------------------
    generate
        for (genvar lvl = 1; lvl <= LVL; lvl++) begin : g_level
            localparam int D = 2 ** (lvl - 1);  // combine distance
            for (genvar i = 0; i < N; i++) begin : g_node
                if (i >= D) begin : g_merge
                    assign gen[lvl][i] = gen[lvl-1][i] | (prp[lvl-1][i] & gen[lvl-1][i-D]);
                    assign prp[lvl][i] = prp[lvl-1][i] & prp[lvl-1][i-D];
                end else begin : g_pass
                    assign gen[lvl][i] = gen[lvl-1][i];  // already complete
                    assign prp[lvl][i] = prp[lvl-1][i];
                end
            end
        end
    endgenerate

    // carry into bit i is the full group generate at position i
    assign sum_o = hsum ^ gen[LVL];

endmodule

//--- logic/cp_bus_if.sv
// ------------------------------------------------
// start/valid link between the ALU and one co-processor
// host drives operands and the start pulse, unit answers
// ------------------------------------------------
`timescale 1ns/1ns
`include "alu_macros.svh"

interface cp_bus_if;

    logic                    start;     // one-cycle trigger
    logic [`ALU_XLEN-1:0]    opa;       // data to shift
    logic [`ALU_SHAMT_W-1:0] shamt;     // shift amount
    alu_ctrl_pkg::shift_op_e shift_op;  // function
    logic [`ALU_XLEN-1:0]    res;       // zero unless a result is held
    logic                    valid;     // one-cycle done pulse

    modport host (
        output start, opa, shamt, shift_op,
        input  res, valid
    );

    modport unit (
        input  start, opa, shamt, shift_op,
        output res, valid
    );

endinterface

//--- logic/alu_cp_pkg.sv
// ------------------------------------------------
// co-processor side types
// slot numbering, shifter FSM states and monitor state
// ------------------------------------------------
`include "alu_macros.svh"

package alu_cp_pkg;

    typedef enum logic [0:0] {
        SHIFT    = 1'd0,    // serial shifter
        RESERVED = 1'd1     // empty slot, never answers
    } cp_slot_e;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,   // shifting
        DONE = 2'b10    // result held
    } shift_state_e;

    typedef struct packed {
        logic                          run;  // operation in flight
        logic                          fin;  // done seen last cycle
        logic                          exc;  // timeout exception
        logic [`ALU_CP_TIMEOUT_BITS:0] cnt;  // cycles since start
    } cp_mon_t;

endpackage

//--- logic/alu_ctrl_pkg.sv
// ------------------------------------------------
// control encodings of the ALU
// opcode select, shift function and comparator bit positions
// ------------------------------------------------
package alu_ctrl_pkg;

    // ------------------------------------------------
    // result select
    // ------------------------------------------------
    typedef enum logic [2:0] {
        ADD  = 3'b000,  // opa + opb
        SUB  = 3'b001,  // opa - opb
        CP   = 3'b010,  // co-processor result
        SLT  = 3'b011,  // set less than, signed/unsigned
        MOVB = 3'b100,  // pass operand b
        XOR  = 3'b101,  // rs1 ^ opb
        OR   = 3'b110,  // rs1 | opb
        AND  = 3'b111   // rs1 & opb
    } alu_op_e;

    // ------------------------------------------------
    // shifter function
    // ------------------------------------------------
    typedef enum logic [1:0] {
        SLL = 2'b00,    // logical left
        SRL = 2'b01,    // logical right
        SRA = 2'b10     // arithmetic right
    } shift_op_e;

    // comparator result bits
    localparam int cmp_eq_idx = 0;  // rs1 == rs2
    localparam int cmp_lt_idx = 1;  // rs1 < rs2

endpackage

//--- logic/alu_macros.svh
// ------------------------------------------------
// global sizes of the ALU data path and co-processor slots
// include in any file that needs the widths or timeout length
// ------------------------------------------------
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_XLEN 32            // data path width
`define ALU_SHAMT_W 5          // shift amount width, log2 of xlen

// co-processor timeout, exception after about 2**bits cycles
`define ALU_CP_TIMEOUT_BITS 7

`define ALU_CP_NUM 2           // trigger bits, shifter + empty slot

`endif
